//--- opb_pkg.sv
package opb_pkg;

  // ------------------------------
  // bus geometry
  // ------------------------------

  localparam int OPB_AWIDTH  = 32;
  localparam int OPB_DWIDTH  = 32;
  localparam int OPB_BEWIDTH = OPB_DWIDTH / 8;

  // OPB numbers its bits big-endian, so bit 0 is the most significant bit
  typedef logic [0:OPB_AWIDTH-1]  opb_addr_t;
  typedef logic [0:OPB_DWIDTH-1]  opb_data_t;

  // byte enable 0 selects data bits 0 to 7, the most significant byte
  typedef logic [0:OPB_BEWIDTH-1] opb_be_t;

  // ------------------------------
  // slave side bundles
  // ------------------------------

  // master to slave, 71 bits
  typedef struct packed {
    opb_addr_t addr;
    opb_be_t   be;
    opb_data_t wdata;
    logic      rnw;
    logic      select;
    logic      seq_addr;
  } opb_req_t;

  // slave to master, 36 bits
  // read data has to be zero whenever xfer_ack is low, since slaves are OR-ed
  typedef struct packed {
    opb_data_t rdata;
    logic      xfer_ack;
    logic      err_ack;
    logic      retry;
    logic      tout_sup;
  } opb_rsp_t;

endpackage

//--- sys_pkg.sv
package sys_pkg;

  localparam int CNT_WIDTH = 32;
  localparam int IRQ_LINES = 16;

  // word index inside the register window
  typedef logic [3:0]           reg_idx_t;

  // free-running count of fabric clock edges
  typedef logic [0:CNT_WIDTH-1] cnt_t;

  // one bit per application interrupt line
  typedef logic [IRQ_LINES-1:0] irq_vec_t;

  // bus-side steps of the counter snapshot handshake
  typedef enum logic [1:0] {
    LATCH_IDLE = 2'd0,
    LATCH_REQ  = 2'd1,
    LATCH_WAIT = 2'd2
  } latch_state_t;

  // ------------------------------
  // address window
  // ------------------------------

  localparam logic [31:0] SYS_BASEADDR = 32'h4000_0000;
  localparam logic [31:0] SYS_HIGHADDR = 32'h4000_003F;

  // ------------------------------
  // board identity
  // ------------------------------

  localparam logic [15:0] BOARD_ID     = 16'h5A31;
  localparam logic [15:0] REV_MAJOR    = 16'h0001;
  localparam logic [15:0] REV_MINOR    = 16'h0003;
  localparam logic [15:0] REV_RCS      = 16'h0120;
  localparam logic [15:0] RCS_UPTODATE = 16'h0001;

  localparam logic [31:0] SCRATCH_RESET = 32'hA5A5_0F0F;

  // ------------------------------
  // register map
  // ------------------------------

  localparam reg_idx_t REG_ID       = 4'd0;
  localparam reg_idx_t REG_REV      = 4'd1;
  localparam reg_idx_t REG_CTRL     = 4'd2;
  localparam reg_idx_t REG_SCRATCH  = 4'd3;
  localparam reg_idx_t REG_FABCNT   = 4'd4;
  localparam reg_idx_t REG_IRQ_STAT = 4'd5;
  localparam reg_idx_t REG_IRQ_MASK = 4'd6;

endpackage

//--- sys_regs.sv
`timescale 1ns/1ps

module sys_regs (
  input  logic               OPB_Clk,
  input  logic               rst_fabRR,
  input  opb_pkg::opb_req_t  req,
  output opb_pkg::opb_rsp_t  rsp,
  output logic               soft_reset,
  output logic               latch_start,
  input  logic               latch_done,
  input  sys_pkg::cnt_t      fab_count,
  output logic               irq_clr,
  output logic               irq_mask_wr,
  output opb_pkg::opb_data_t wr_data,
  input  sys_pkg::irq_vec_t  irq_pending,
  input  sys_pkg::irq_vec_t  irq_mask
);

  import opb_pkg::*;
  import sys_pkg::*;

  opb_addr_t offset;
  reg_idx_t  idx;
  logic      addr_match;
  logic      access;
  logic      wr_access;
  logic      xfer_ack;
  logic      bus_wait;
  opb_data_t scratch_pad;
  opb_data_t rd_data;

  // ------------------------------
  // address decode
  // ------------------------------

  assign addr_match = (req.addr >= SYS_BASEADDR) && (req.addr <= SYS_HIGHADDR);
  assign offset     = req.addr - SYS_BASEADDR;

  // bits 26 to 29 of the big-endian offset are byte address bits 5 down to 2
  assign idx = offset[26:29];

  // select is ignored right after our own acknowledge and while a counter
  // read is still outstanding
  // seq_addr is not looked at and a burst is served as a run of single accesses
  assign access    = addr_match && req.select && !xfer_ack && !bus_wait;
  assign wr_access = access && !req.rnw;

  // ------------------------------
  // acknowledge and writes
  // ------------------------------

  always_ff @(posedge OPB_Clk) begin
    if (rst_fabRR) begin
      xfer_ack    <= 1'b0;
      soft_reset  <= 1'b0;
      latch_start <= 1'b0;
      bus_wait    <= 1'b0;
      scratch_pad <= SCRATCH_RESET;
    end else begin
      xfer_ack    <= 1'b0;
      soft_reset  <= 1'b0;
      latch_start <= 1'b0;

      if (bus_wait) begin
        if (latch_done) begin
          xfer_ack <= 1'b1;
          bus_wait <= 1'b0;
        end
      end else if (access) begin
        if (req.rnw) begin
          if (idx == REG_FABCNT) begin
            // hold the access until the snapshot has crossed over
            bus_wait    <= 1'b1;
            latch_start <= 1'b1;
          end else begin
            xfer_ack <= 1'b1;
          end
        end else begin
          xfer_ack <= 1'b1;
          case (idx)
            REG_CTRL: begin
              soft_reset <= req.be[3] && req.wdata[31];
            end
            REG_SCRATCH: begin
              for (int b = 0; b < 4; b++) begin
                if (req.be[b]) begin
                  scratch_pad[8*b +: 8] <= req.wdata[8*b +: 8];
                end
              end
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

  // interrupt register writes are passed on at the edge that starts the access
  assign irq_clr     = wr_access && (idx == REG_IRQ_STAT);
  assign irq_mask_wr = wr_access && (idx == REG_IRQ_MASK);
  assign wr_data     = req.wdata;

  // ------------------------------
  // read multiplexer
  // ------------------------------

  always_comb begin
    rd_data = '0;
    if (xfer_ack && req.rnw) begin
      case (idx)
        REG_ID:       rd_data = {BOARD_ID, REV_MAJOR};
        REG_REV:      rd_data = {REV_MINOR, REV_RCS};
        REG_CTRL:     rd_data = {15'd0, (RCS_UPTODATE != 16'd0), 15'd0, soft_reset};
        REG_SCRATCH:  rd_data = scratch_pad;
        REG_FABCNT:   rd_data = fab_count;
        REG_IRQ_STAT: rd_data = {16'd0, irq_pending};
        REG_IRQ_MASK: rd_data = {16'd0, irq_mask};
        default:      rd_data = '0;
      endcase
    end
  end

  assign rsp.rdata    = rd_data;
  assign rsp.xfer_ack = xfer_ack;
  assign rsp.err_ack  = 1'b0;
  assign rsp.retry    = 1'b0;
  assign rsp.tout_sup = 1'b0;

endmodule

//--- fab_count_latch.sv
`timescale 1ns/1ps

module fab_count_latch (
  input  logic          OPB_Clk,
  input  logic          rst_fabRR,
  input  logic          fab_clk,
  input  logic          latch_start,
  output logic          latch_done,
  output sys_pkg::cnt_t fab_count
);

  import sys_pkg::*;

  logic         fab_rst_r;
  logic         fab_rst_rr;
  cnt_t         fab_counter;
  cnt_t         fab_capture;
  logic         req_r;
  logic         req_rr;
  logic         val_got;

  latch_state_t state;
  logic         val_req;
  logic         got_r;
  logic         got_rr;

  // ------------------------------
  // fabric clock domain
  // ------------------------------

  always_ff @(posedge fab_clk) begin
    fab_rst_r  <= rst_fabRR;
    fab_rst_rr <= fab_rst_r;
  end

  always_ff @(posedge fab_clk) begin
    if (fab_rst_rr) begin
      fab_counter <= '0;
      req_r       <= 1'b0;
      req_rr      <= 1'b0;
      val_got     <= 1'b0;
    end else begin
      fab_counter <= fab_counter + 1'b1;
      req_r       <= val_req;
      req_rr      <= req_r;
      if (req_rr) begin
        val_got <= 1'b1;
      end else begin
        val_got <= 1'b0;
      end
    end
  end

  // the captured value stays put for as long as got is high
  always_ff @(posedge fab_clk) begin
    if (req_rr && !val_got) begin
      fab_capture <= fab_counter;
    end
  end

  // ------------------------------
  // bus clock domain
  // ------------------------------

  always_ff @(posedge OPB_Clk) begin
    if (rst_fabRR) begin
      state  <= LATCH_IDLE;
      got_r  <= 1'b0;
      got_rr <= 1'b0;
    end else begin
      got_r  <= val_got;
      got_rr <= got_r;
      case (state)
        LATCH_IDLE: if (latch_start) state <= LATCH_REQ;
        LATCH_REQ:  if (got_rr) state <= LATCH_WAIT;
        LATCH_WAIT: if (!got_rr) state <= LATCH_IDLE;
        default:    state <= LATCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (state == LATCH_REQ && got_rr) begin
      fab_count <= fab_capture;
    end
  end

  assign val_req    = (state == LATCH_REQ);
  assign latch_done = (state == LATCH_WAIT) && !got_rr;

endmodule

//--- irq_chain.sv
`timescale 1ns/1ps

module irq_chain (
  input  logic               OPB_Clk,
  input  logic               rst_fabRR,
  input  sys_pkg::irq_vec_t  app_irq,
  input  logic               irq_clr,
  input  logic               irq_mask_wr,
  input  opb_pkg::opb_data_t wr_data,
  output sys_pkg::irq_vec_t  irq_pending,
  output sys_pkg::irq_vec_t  irq_mask,
  output logic               irq_n
);

  import sys_pkg::*;

  irq_vec_t wr_vec;
  irq_vec_t clr_vec;

  // the interrupt registers sit in the low half of the big-endian word
  assign wr_vec  = wr_data[16:31];
  assign clr_vec = irq_clr ? wr_vec : '0;

  always_ff @(posedge OPB_Clk) begin
    if (rst_fabRR) begin
      irq_pending <= '0;
      irq_mask    <= '0;
    end else begin
      // a line that is high in the same cycle as its clear keeps the bit set
      irq_pending <= (irq_pending & ~clr_vec) | app_irq;
      if (irq_mask_wr) begin
        irq_mask <= wr_vec;
      end
    end
  end

  assign irq_n = ~|(irq_pending & irq_mask);

endmodule

//--- sys_block.sv
`timescale 1ns/1ps

module sys_block (
  input  logic              OPB_Clk,
  input  logic              rst_fabRR,
  input  opb_pkg::opb_req_t opb_req,
  output opb_pkg::opb_rsp_t opb_rsp,
  output logic              soft_reset,
  output logic              irq_n,
  input  sys_pkg::irq_vec_t app_irq,
  input  logic              fab_clk
);

  import opb_pkg::*;
  import sys_pkg::*;

  logic      latch_start;
  logic      latch_done;
  cnt_t      fab_count;
  logic      irq_clr;
  logic      irq_mask_wr;
  opb_data_t wr_data;
  irq_vec_t  irq_pending;
  irq_vec_t  irq_mask;

  sys_regs u_regs (
    .OPB_Clk     (OPB_Clk),
    .rst_fabRR   (rst_fabRR),
    .req         (opb_req),
    .rsp         (opb_rsp),
    .soft_reset  (soft_reset),
    .latch_start (latch_start),
    .latch_done  (latch_done),
    .fab_count   (fab_count),
    .irq_clr     (irq_clr),
    .irq_mask_wr (irq_mask_wr),
    .wr_data     (wr_data),
    .irq_pending (irq_pending),
    .irq_mask    (irq_mask)
  );

  fab_count_latch u_latch (
    .OPB_Clk     (OPB_Clk),
    .rst_fabRR   (rst_fabRR),
    .fab_clk     (fab_clk),
    .latch_start (latch_start),
    .latch_done  (latch_done),
    .fab_count   (fab_count)
  );

  irq_chain u_irq (
    .OPB_Clk     (OPB_Clk),
    .rst_fabRR   (rst_fabRR),
    .app_irq     (app_irq),
    .irq_clr     (irq_clr),
    .irq_mask_wr (irq_mask_wr),
    .wr_data     (wr_data),
    .irq_pending (irq_pending),
    .irq_mask    (irq_mask),
    .irq_n       (irq_n)
  );

endmodule

//--- sys_block_assert.sv
`timescale 1ns/1ps

module sys_block_assert (
  input logic              OPB_Clk,
  input logic              rst_fabRR,
  input opb_pkg::opb_rsp_t opb_rsp
);

  int fail_count;

  initial fail_count = 0;

  // a slave acknowledges for exactly one cycle
  ack_single: assert property (@(posedge OPB_Clk) disable iff (rst_fabRR)
    !(opb_rsp.xfer_ack && $past(opb_rsp.xfer_ack)))
  else begin
    fail_count++;
    $error("transfer acknowledge stayed high for two cycles");
  end

  no_err_retry: assert property (@(posedge OPB_Clk) disable iff (rst_fabRR)
    !opb_rsp.err_ack && !opb_rsp.retry && !opb_rsp.tout_sup)
  else begin
    fail_count++;
    $error("error acknowledge, retry or timeout suppress was driven");
  end

  // slaves are OR-ed onto the read bus
  rdata_idle_zero: assert property (@(posedge OPB_Clk) disable iff (rst_fabRR)
    opb_rsp.xfer_ack || (opb_rsp.rdata == '0))
  else begin
    fail_count++;
    $error("read data not zero outside the acknowledge");
  end

endmodule

bind sys_block sys_block_assert u_assert (
  .OPB_Clk   (OPB_Clk),
  .rst_fabRR (rst_fabRR),
  .opb_rsp   (opb_rsp)
);

//--- tb_sys_block.sv
`timescale 1ns/1ps

module tb_sys_block;

  import opb_pkg::*;
  import sys_pkg::*;

  localparam int OP_TIME_NS = 200;

  logic     OPB_Clk;
  logic     fab_clk;
  logic     rst_fabRR;
  opb_req_t opb_req;
  opb_rsp_t opb_rsp;
  logic     soft_reset;
  logic     irq_n;
  irq_vec_t app_irq;

  // operations as read from the data file, one entry per line
  logic [3:0] op_kind[$];
  reg_idx_t   op_idx[$];
  opb_be_t    op_be[$];
  opb_data_t  op_data[$];
  irq_vec_t   op_irq[$];
  int         n_ops = 0;

  sys_block uut (
    .OPB_Clk    (OPB_Clk),
    .rst_fabRR  (rst_fabRR),
    .opb_req    (opb_req),
    .opb_rsp    (opb_rsp),
    .soft_reset (soft_reset),
    .irq_n      (irq_n),
    .app_irq    (app_irq),
    .fab_clk    (fab_clk)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  initial begin
    fab_clk = 1'b0;
    forever #3.5 fab_clk = ~fab_clk;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic data_compare(input opb_data_t got, input opb_data_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic irq_compare(input irq_vec_t got, input irq_vec_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic bit_compare(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic count_in_range(input cnt_t got, input cnt_t lo, input cnt_t hi,
                                input string what);
    if (got < lo || got > hi) begin
      $display("mismatch at %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
      abort_run();
    end
  endtask

  // ------------------------------
  // bus master
  // ------------------------------

  // holds select until the acknowledge and notes any soft reset pulse on the way
  task automatic bus_access(input reg_idx_t idx, input logic rnw, input opb_be_t be,
                            input opb_data_t wdata, output opb_data_t rdata,
                            output logic pulse_seen);
    @(posedge OPB_Clk);
    opb_req.addr   <= SYS_BASEADDR + {26'd0, idx, 2'b00};
    opb_req.be     <= be;
    opb_req.wdata  <= wdata;
    opb_req.rnw    <= rnw;
    opb_req.select <= 1'b1;
    pulse_seen = 1'b0;
    do begin
      @(negedge OPB_Clk);
      pulse_seen = pulse_seen | soft_reset;
    end while (opb_rsp.xfer_ack !== 1'b1);
    rdata = opb_rsp.rdata;
    @(posedge OPB_Clk);
    opb_req.select <= 1'b0;
  endtask

  initial begin
    wait (n_ops > 0);
    #(n_ops * OP_TIME_NS);
    $display("timeout: the operations did not finish within %0d ns", n_ops * OP_TIME_NS);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  // the bound checker counts its assertion failures
  initial begin
    wait (uut.u_assert.fail_count != 0);
    $display("a bus protocol assertion failed");
    abort_run();
  end

  initial begin
    int          fd;
    string       line;
    logic [31:0] fields[5];
    opb_data_t   rdata;
    opb_data_t   byte_mask;
    opb_data_t   scratch_model;
    irq_vec_t    pending_model;
    irq_vec_t    mask_model;
    irq_vec_t    pattern;
    logic        pulse;
    cnt_t        last_count;
    cnt_t        lo;
    cnt_t        hi;
    realtime     last_time;
    int          ticks;
    logic        have_count;

    rst_fabRR = 1'b1;
    opb_req   = '0;
    app_irq   = '0;

    fd = $fopen("sys_block_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open sys_block_input.txt for reading");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h %h", fields[0], fields[1], fields[2], fields[3],
                    fields[4]) == 5) begin
          op_kind.push_back(fields[0][3:0]);
          op_idx.push_back(fields[1][3:0]);
          op_be.push_back(fields[2][3:0]);
          op_data.push_back(fields[3]);
          op_irq.push_back(fields[4][15:0]);
        end
      end
    end
    $fclose(fd);
    if (op_kind.size() == 0) begin
      $display("the data file holds no operations");
      abort_run();
    end
    n_ops = op_kind.size();

    repeat (10) @(posedge OPB_Clk);
    rst_fabRR <= 1'b0;
    void'($urandom(19));

    scratch_model = SCRATCH_RESET;
    pending_model = '0;
    mask_model    = '0;
    have_count    = 1'b0;

    for (int i = 0; i < n_ops; i++) begin
      case (op_kind[i])
        4'd0: begin
          bus_access(op_idx[i], 1'b0, op_be[i], op_data[i], rdata, pulse);
          bit_compare(pulse, (op_idx[i] == REG_CTRL) && op_be[i][3] && op_data[i][31],
                      "soft reset pulse");
          byte_mask = {{8{op_be[i][0]}}, {8{op_be[i][1]}}, {8{op_be[i][2]}}, {8{op_be[i][3]}}};
          if (op_idx[i] == REG_SCRATCH)
            scratch_model = (scratch_model & ~byte_mask) | (op_data[i] & byte_mask);
          if (op_idx[i] == REG_IRQ_STAT)
            pending_model = pending_model & ~op_data[i][16:31];
          if (op_idx[i] == REG_IRQ_MASK)
            mask_model = op_data[i][16:31];
        end
        4'd1: begin
          bus_access(op_idx[i], 1'b1, op_be[i], '0, rdata, pulse);
          data_compare(rdata, op_data[i], $sformatf("word %0d", op_idx[i]));
        end
        4'd2: begin
          bus_access(op_idx[i], 1'b1, op_be[i], '0, rdata, pulse);
          case (op_idx[i])
            REG_SCRATCH:  data_compare(rdata, scratch_model, "scratch pad");
            REG_IRQ_STAT: irq_compare(rdata[16:31], pending_model, "interrupt status");
            REG_IRQ_MASK: irq_compare(rdata[16:31], mask_model, "interrupt mask");
            default: begin
              $display("operation %0d reads a word that has no model", i);
              abort_run();
            end
          endcase
        end
        4'd3: begin
          bus_access(op_idx[i], 1'b1, op_be[i], '0, rdata, pulse);
          if (have_count) begin
            // one count per 7 ns of fabric clock since the previous snapshot
            ticks = int'(($realtime - last_time) / 7.0);
            lo = (ticks > 11) ? last_count + cnt_t'(ticks - 10) : last_count + 32'd1;
            hi = last_count + cnt_t'(ticks + 10);
            count_in_range(cnt_t'(rdata), lo, hi, "fabric counter");
          end
          last_count = cnt_t'(rdata);
          last_time  = $realtime;
          have_count = 1'b1;
        end
        4'd4: begin
          pattern = irq_vec_t'($urandom) & op_irq[i];
          @(posedge OPB_Clk);
          app_irq <= pattern;
          repeat (2) @(posedge OPB_Clk);
          app_irq <= '0;
          pending_model = pending_model | pattern;
        end
        default: begin
          $display("operation %0d has an unknown kind %0d", i, op_kind[i]);
          abort_run();
        end
      endcase
      @(negedge OPB_Clk);
      bit_compare(irq_n, (pending_model & mask_model) == '0, "irq_n");
    end

    if (uut.u_assert.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("a bus protocol assertion failed");
      abort_run();
    end
  end

endmodule

//--- sys_block_input.txt
# kind idx be data irq, all hex; kind 0 write, 1 read against data, 2 read against the
# testbench model, 3 counter read, 4 random interrupt pulse limited to the irq column
1 0 f 5a310001 0000
1 1 f 00030120 0000
1 3 f a5a50f0f 0000
3 4 f 00000000 0000
0 3 f 12345678 0000
2 3 f 00000000 0000
0 3 1 000000cc 0000
0 3 6 00abcd00 0000
2 3 f 00000000 0000
0 3 8 ee000000 0000
1 3 f eeabcdcc 0000
0 2 f 80000001 0000
0 2 f 00000000 0000
0 2 e 00000001 0000
1 2 f 00010000 0000
3 4 f 00000000 0000
4 0 0 00000000 00ff
4 0 0 00000000 0f0f
2 5 f 00000000 0000
2 6 f 00000000 0000
0 6 f 0000ffff 0000
0 5 f 0000ffff 0000
2 5 f 00000000 0000
4 0 0 00000000 ff00
0 6 f 0000f000 0000
0 5 f 0000ffff 0000
1 7 f 00000000 0000
1 f f 00000000 0000
3 4 f 00000000 0000

//--- compile.f
opb_pkg.sv
sys_pkg.sv
sys_regs.sv
fab_count_latch.sv
irq_chain.sv
sys_block.sv
sys_block_assert.sv
tb_sys_block.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sys_block
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
